/* logic/mem_pkg.sv */
package mem_pkg;

    // Ownership state of the memory arbiter.
    // In the open state port 1 wins any conflict.
    // In the held state port 2 was granted in the previous cycle and keeps the memory
    // for as long as it holds its request.
    typedef enum logic {
        ARB_OPEN   = 1'b0,
        ARB_HELD_2 = 1'b1
    } arb_state_e;

    // Default word address width of both requesters.
    parameter int DEFAULT_ADDRESS_WIDTH = 32;

    // Default width of one memory word.
    parameter int DEFAULT_DATA_WIDTH = 32;

    // Default depth of the shared memory in words.
    // Only the low address bits index the array.
    parameter int DEFAULT_MEM_WORDS = 256;

endpackage

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic clk,
    input  logic reset,
    input  logic req_1,
    input  logic req_2,
    output logic grant_1,
    output logic grant_2,
    output logic mem_req
);

    import mem_pkg::*;

    // One bit of ownership state, updated on the rising edge.
    // It remembers whether port 2 was granted in the cycle that just ended.
    arb_state_e state;

    // Tells whether port 2 owns the memory from the previous cycle.
    logic held_2;

    assign held_2 = (state == ARB_HELD_2);

    // Port 2 wins when port 1 is idle, or when it already owns the memory.
    // Once it has won, a request from port 1 cannot take the memory away
    // until req_2 falls.
    assign grant_2 = req_2 & (held_2 | ~req_1);

    // Port 1 has priority in every other case.
    assign grant_1 = req_1 & ~grant_2;

    // The memory sees an access whenever either port is granted.
    // The two grants are exclusive by construction.
    assign mem_req = grant_1 | grant_2;

    // The state follows grant_2 of the cycle that ends at this edge.
    // Dropping req_2 for a single cycle therefore returns the arbiter to the
    // open state, and port 1 wins the next conflict.
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ARB_OPEN;
        end else if (grant_2) begin
            state <= ARB_HELD_2;
        end else begin
            state <= ARB_OPEN;
        end
    end

endmodule

/* logic/port_mux.sv */
`timescale 1ns/1ps

module port_mux #(
    parameter int ADDRESS_WIDTH = mem_pkg::DEFAULT_ADDRESS_WIDTH,
    parameter int DATA_WIDTH    = mem_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                     grant_1,
    input  logic                     store_1,
    input  logic                     store_2,
    input  logic [ADDRESS_WIDTH-1:0] addr_1,
    input  logic [ADDRESS_WIDTH-1:0] addr_2,
    input  logic [DATA_WIDTH-1:0]    wdata_1,
    input  logic [DATA_WIDTH-1:0]    wdata_2,
    output logic                     mem_store,
    output logic [ADDRESS_WIDTH-1:0] mem_addr,
    output logic [DATA_WIDTH-1:0]    mem_wdata
);

    // Port 1 drives the memory side while it is granted.
    // Port 2 drives it in every other cycle, granted or not.
    // When no port is granted the fields of port 2 still reach the memory,
    // but the memory ignores them because mem_req is low.
    always_comb begin
        if (grant_1) begin
            mem_store = store_1;
            mem_addr  = addr_1;
            mem_wdata = wdata_1;
        end else begin
            mem_store = store_2;
            mem_addr  = addr_2;
            mem_wdata = wdata_2;
        end
    end

endmodule

/* logic/shared_ram.sv */
`timescale 1ns/1ps

module shared_ram #(
    parameter int ADDRESS_WIDTH = mem_pkg::DEFAULT_ADDRESS_WIDTH,
    parameter int DATA_WIDTH    = mem_pkg::DEFAULT_DATA_WIDTH,
    parameter int MEM_WORDS     = mem_pkg::DEFAULT_MEM_WORDS
) (
    input  logic                     clk,
    input  logic                     mem_req,
    input  logic                     mem_store,
    input  logic [ADDRESS_WIDTH-1:0] mem_addr,
    input  logic [DATA_WIDTH-1:0]    mem_wdata,
    output logic [DATA_WIDTH-1:0]    mem_rdata
);

    // Number of low address bits that select a word.
    // A depth of one word still needs a one bit index.
    localparam int INDEX_WIDTH = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    // The word array itself.
    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    // Word index taken from the low bits of the address.
    // Higher address bits alias onto the same words.
    logic [INDEX_WIDTH-1:0] index;

    // Qualified strobes for the two kinds of access.
    logic wr_en;
    logic rd_en;

    assign index = mem_addr[INDEX_WIDTH-1:0];
    assign wr_en = mem_req & mem_store;
    assign rd_en = mem_req & ~mem_store;

    // A write lands at the edge that accepts it.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[index] <= mem_wdata;
        end
    end

    // A read is registered at the accepting edge, so the word is on mem_rdata
    // for the whole next cycle.
    // The register keeps its value until the next accepted read.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            mem_rdata <= mem[index];
        end
    end

endmodule

/* logic/read_return.sv */
`timescale 1ns/1ps

module read_return #(
    parameter int DATA_WIDTH = mem_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_req,
    input  logic                  mem_store,
    input  logic                  grant_1,
    input  logic [DATA_WIDTH-1:0] mem_rdata,
    output logic                  rvalid_1,
    output logic                  rvalid_2,
    output logic [DATA_WIDTH-1:0] rdata_1,
    output logic [DATA_WIDTH-1:0] rdata_2
);

    // Last word returned to each port.
    logic [DATA_WIDTH-1:0] held_1;
    logic [DATA_WIDTH-1:0] held_2;

    // An accepted read is steered by the grant of its own cycle.
    // A read that is not granted to port 1 belongs to port 2, since mem_req is high.
    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid_1 <= 1'b0;
            rvalid_2 <= 1'b0;
        end else begin
            rvalid_1 <= mem_req & ~mem_store & grant_1;
            rvalid_2 <= mem_req & ~mem_store & ~grant_1;
        end
    end

    // The shared read word is copied into the holding register of the port
    // whose pulse is active, and the other port keeps its old word.
    always_ff @(posedge clk) begin
        if (reset) begin
            held_1 <= '0;
            held_2 <= '0;
        end else begin
            if (rvalid_1) begin
                held_1 <= mem_rdata;
            end
            if (rvalid_2) begin
                held_2 <= mem_rdata;
            end
        end
    end

    // During the pulse the fresh word passes straight through.
    // After it the holding register keeps the port's result.
    assign rdata_1 = rvalid_1 ? mem_rdata : held_1;
    assign rdata_2 = rvalid_2 ? mem_rdata : held_2;

endmodule

/* logic/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int ADDRESS_WIDTH = mem_pkg::DEFAULT_ADDRESS_WIDTH,
    parameter int DATA_WIDTH    = mem_pkg::DEFAULT_DATA_WIDTH,
    parameter int MEM_WORDS     = mem_pkg::DEFAULT_MEM_WORDS
) (
    input  logic                     clk,
    input  logic                     reset,

    // Port 1 is the data access side.
    input  logic                     req_1,
    input  logic                     store_1,
    input  logic [ADDRESS_WIDTH-1:0] addr_1,
    input  logic [DATA_WIDTH-1:0]    wdata_1,
    output logic                     grant_1,
    output logic                     rvalid_1,
    output logic [DATA_WIDTH-1:0]    rdata_1,

    // Port 2 is the instruction fetch side.
    input  logic                     req_2,
    input  logic                     store_2,
    input  logic [ADDRESS_WIDTH-1:0] addr_2,
    input  logic [DATA_WIDTH-1:0]    wdata_2,
    output logic                     grant_2,
    output logic                     rvalid_2,
    output logic [DATA_WIDTH-1:0]    rdata_2
);

    // Memory side of the granted port.
    logic                     mem_req;
    logic                     mem_store;
    logic [ADDRESS_WIDTH-1:0] mem_addr;
    logic [DATA_WIDTH-1:0]    mem_wdata;
    logic [DATA_WIDTH-1:0]    mem_rdata;

    // Grants are decided in the request's own cycle.
    mem_arbiter u_arbiter (
        .clk     (clk),
        .reset   (reset),
        .req_1   (req_1),
        .req_2   (req_2),
        .grant_1 (grant_1),
        .grant_2 (grant_2),
        .mem_req (mem_req)
    );

    port_mux #(
        .ADDRESS_WIDTH (ADDRESS_WIDTH),
        .DATA_WIDTH    (DATA_WIDTH)
    ) u_mux (
        .grant_1   (grant_1),
        .store_1   (store_1),
        .store_2   (store_2),
        .addr_1    (addr_1),
        .addr_2    (addr_2),
        .wdata_1   (wdata_1),
        .wdata_2   (wdata_2),
        .mem_store (mem_store),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    shared_ram #(
        .ADDRESS_WIDTH (ADDRESS_WIDTH),
        .DATA_WIDTH    (DATA_WIDTH),
        .MEM_WORDS     (MEM_WORDS)
    ) u_ram (
        .clk       (clk),
        .mem_req   (mem_req),
        .mem_store (mem_store),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    // Read results come back one cycle after the grant cycle.
    read_return #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_return (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_store (mem_store),
        .grant_1   (grant_1),
        .mem_rdata (mem_rdata),
        .rvalid_1  (rvalid_1),
        .rvalid_2  (rvalid_2),
        .rdata_1   (rdata_1),
        .rdata_2   (rdata_2)
    );

endmodule

/* testbench/mem_subsystem_chk.sv */
`timescale 1ns/1ps

module mem_subsystem_chk (
    input logic        clk,
    input logic        reset,
    input logic        req_1,
    input logic        req_2,
    input logic        grant_1,
    input logic        grant_2,
    input logic        mem_store,
    input logic        rvalid_1,
    input logic        rvalid_2,
    input logic [31:0] rdata_1,
    input logic [31:0] rdata_2
);

    // Number of assertion failures seen so far.
    int fail_count = 0;

    // Our own copy of the ownership state, taken from the grant of the last cycle.
    logic held;

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= 1'b0;
        end else begin
            held <= grant_2;
        end
    end

    // The two grants never overlap, and no grant appears without its request.
    exclusive_grants: assert property (@(posedge clk) disable iff (reset)
        !(grant_1 && grant_2))
        else begin
            $error("grant_1 and grant_2 high together");
            fail_count++;
        end
    grant_needs_req: assert property (@(posedge clk) disable iff (reset)
        (!grant_1 || req_1) && (!grant_2 || req_2))
        else begin
            $error("grant without request");
            fail_count++;
        end

    // With the state open, port 1 wins a conflict.
    port_1_priority: assert property (@(posedge clk) disable iff (reset)
        (!held && req_1 && req_2) |-> (grant_1 && !grant_2))
        else begin
            $error("port 1 lost an open conflict");
            fail_count++;
        end

    // Port 2 keeps the memory while it holds its request.
    port_2_ownership: assert property (@(posedge clk) disable iff (reset)
        (held && req_2) |-> grant_2)
        else begin
            $error("port 2 lost ownership");
            fail_count++;
        end

    // A granted read returns on its own port in the next cycle, and only then.
    // A read accepted while reset is high returns nothing.
    read_return_1: assert property (@(posedge clk) disable iff (reset)
        rvalid_1 == $past(grant_1 && !mem_store && !reset))
        else begin
            $error("rvalid_1 does not follow a port 1 read");
            fail_count++;
        end
    read_return_2: assert property (@(posedge clk) disable iff (reset)
        rvalid_2 == $past(grant_2 && !mem_store && !reset))
        else begin
            $error("rvalid_2 does not follow a port 2 read");
            fail_count++;
        end

    // Outside its pulse a port keeps the word it was given.
    rdata_1_held: assert property (@(posedge clk) disable iff (reset)
        !rvalid_1 |-> $stable(rdata_1))
        else begin
            $error("rdata_1 changed without rvalid_1");
            fail_count++;
        end
    rdata_2_held: assert property (@(posedge clk) disable iff (reset)
        !rvalid_2 |-> $stable(rdata_2))
        else begin
            $error("rdata_2 changed without rvalid_2");
            fail_count++;
        end

    // Reset clears both return paths.
    reset_clears: assert property (@(posedge clk)
        reset |=> (!rvalid_1 && !rvalid_2 && rdata_1 == 0 && rdata_2 == 0))
        else begin
            $error("return path not cleared by reset");
            fail_count++;
        end

endmodule

bind mem_subsystem mem_subsystem_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .req_1     (req_1),
    .req_2     (req_2),
    .grant_1   (grant_1),
    .grant_2   (grant_2),
    .mem_store (mem_store),
    .rvalid_1  (rvalid_1),
    .rvalid_2  (rvalid_2),
    .rdata_1   (rdata_1),
    .rdata_2   (rdata_2)
);

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;

    logic clk;
    logic reset;
    logic req_1, store_1, grant_1, rvalid_1;
    logic req_2, store_2, grant_2, rvalid_2;
    logic [31:0] addr_1, wdata_1, rdata_1;
    logic [31:0] addr_2, wdata_2, rdata_2;

    // Model of the memory, the ownership state and the pending read returns.
    logic [31:0] model_mem [16];
    logic m_held, pend_1, pend_2;
    logic [31:0] pend_data_1, pend_data_2, last_1, last_2;
    logic seen_g1, seen_g2;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_start = 0;
    logic timed_out = 1'b0;
    logic [31:0] lfsr = 32'd21;

    mem_subsystem #(.MEM_WORDS(16)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR, stepped once for every bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            errors++;
        end
    endtask

    // One clock cycle: drive at the falling edge, compare mid cycle, then advance the model.
    // Reset is released together with the first inputs after it.
    task automatic cycle(input logic r1, input logic s1, input logic [31:0] a1,
                         input logic [31:0] d1, input logic r2, input logic s2,
                         input logic [31:0] a2, input logic [31:0] d2);
        logic eg1;
        logic eg2;
        eg2 = r2 && (m_held || !r1);
        eg1 = r1 && !eg2;
        @(negedge clk);
        reset = 1'b0;
        req_1 = r1;
        store_1 = s1;
        addr_1 = a1;
        wdata_1 = d1;
        req_2 = r2;
        store_2 = s2;
        addr_2 = a2;
        wdata_2 = d2;
        #5;
        if (pend_1) last_1 = pend_data_1;
        if (pend_2) last_2 = pend_data_2;
        check_val("grant_1", eg1, grant_1);
        check_val("grant_2", eg2, grant_2);
        check_val("rvalid_1", pend_1, rvalid_1);
        check_val("rvalid_2", pend_2, rvalid_2);
        check_val("rdata_1", last_1, rdata_1);
        check_val("rdata_2", last_2, rdata_2);
        pend_1 = 1'b0;
        pend_2 = 1'b0;
        if (eg1 && s1) model_mem[a1[3:0]] = d1;
        if (eg1 && !s1) begin
            pend_1 = 1'b1;
            pend_data_1 = model_mem[a1[3:0]];
        end
        if (eg2 && s2) model_mem[a2[3:0]] = d2;
        if (eg2 && !s2) begin
            pend_2 = 1'b1;
            pend_data_2 = model_mem[a2[3:0]];
        end
        m_held = eg2;
        seen_g1 = grant_1;
        seen_g2 = grant_2;
    endtask

    // Holds reset high for three rising edges and clears the model.
    // The next call of cycle releases it.
    // With hold_2 set, port 2 keeps its request high through the reset.
    task automatic apply_reset(input logic hold_2);
        reset = 1'b1;
        req_1 = 1'b0;
        if (!hold_2) begin
            req_2 = 1'b0;
        end
        repeat (2) @(negedge clk);
        m_held = 1'b0;
        pend_1 = 1'b0;
        pend_2 = 1'b0;
        last_1 = '0;
        last_2 = '0;
    endtask

    // Holds one port's request until it is granted, then drops it for a cycle.
    task automatic access(input int port, input logic s, input logic [31:0] a,
                          input logic [31:0] d);
        int n;
        n = 0;
        seen_g1 = 1'b0;
        seen_g2 = 1'b0;
        while (!(port == 1 ? seen_g1 : seen_g2) && n < 20) begin
            if (port == 1) cycle(1'b1, s, a, d, 1'b0, 1'b0, 0, 0);
            else cycle(1'b0, 1'b0, 0, 0, 1'b1, s, a, d);
            n++;
        end
        if (n >= 20) begin
            $display("Timeout: port %0d was never granted", port);
            timed_out = 1'b1;
        end
        cycle(1'b0, 1'b0, 0, 0, 1'b0, 1'b0, 0, 0);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_start || timed_out) tests_failed++;
        $display("test %-12s %s", name, (errors == test_start && !timed_out) ? "ok" : "failed");
        test_start = errors;
    endtask

    task automatic random_traffic(input int cycles);
        logic b1, b2, s1, s2;
        logic [31:0] a1, a2, d1, d2;
        int w1, w2;
        b1 = 0;
        b2 = 0;
        w1 = 0;
        w2 = 0;
        s1 = 0;
        s2 = 0;
        a1 = 0;
        a2 = 0;
        d1 = 0;
        d2 = 0;
        for (int i = 0; i < cycles && !timed_out; i++) begin
            if (!b1 && rand_bits(1)) begin
                b1 = 1;
                s1 = (rand_bits(1) == 32'd1);
                a1 = rand_bits(6);
                d1 = rand_bits(32);
            end
            if (!b2 && rand_bits(1)) begin
                b2 = 1;
                s2 = (rand_bits(1) == 32'd1);
                a2 = rand_bits(6);
                d2 = rand_bits(32);
            end
            cycle(b1, s1, a1, d1, b2, s2, a2, d2);
            // A served port may raise its next request in the very next cycle.
            if (seen_g1) begin
                b1 = 0;
                w1 = 0;
            end else if (b1) begin
                w1++;
            end
            if (seen_g2) begin
                b2 = 0;
                w2 = 0;
            end else if (b2) begin
                w2++;
            end
            if (w1 > 40 || w2 > 40) begin
                $display("Timeout: a random request waited too long for its grant");
                timed_out = 1'b1;
            end
        end
        cycle(1'b0, 1'b0, 0, 0, 1'b0, 1'b0, 0, 0);
    endtask

    initial begin
        reset = 1'b1;
        req_1 = 0;
        store_1 = 0;
        addr_1 = 0;
        wdata_1 = 0;
        req_2 = 0;
        store_2 = 0;
        addr_2 = 0;
        wdata_2 = 0;
        apply_reset(1'b0);
        cycle(1'b0, 1'b0, 0, 0, 1'b0, 1'b0, 0, 0);
        end_test("reset");

        // Fill every word, then read them back through both ports.
        for (int a = 0; a < 16; a++) access(1, 1'b1, a, 32'hA5C30000 ^ (a * 32'h01010101));
        for (int a = 0; a < 16; a++) access(2, 1'b0, a, 0);
        access(2, 1'b1, 32'h25, 32'h12345678);
        access(1, 1'b0, 32'h5, 0);
        end_test("write_read");

        cycle(1'b1, 1'b0, 3, 0, 1'b1, 1'b0, 4, 0);
        cycle(1'b0, 1'b0, 0, 0, 1'b1, 1'b0, 4, 0);
        cycle(1'b0, 1'b0, 0, 0, 1'b0, 1'b0, 0, 0);
        end_test("priority");

        cycle(1'b0, 1'b0, 0, 0, 1'b1, 1'b0, 7, 0);
        repeat (4) cycle(1'b1, 1'b1, 9, 32'hCAFE0001, 1'b1, 1'b0, 8, 0);
        cycle(1'b1, 1'b1, 9, 32'hCAFE0001, 1'b0, 1'b0, 0, 0);
        cycle(1'b0, 1'b0, 0, 0, 1'b0, 1'b0, 0, 0);
        end_test("ownership");

        // Port 2 owns the memory and keeps req_2 high through the reset.
        // Without the reset it would still own the memory in the first conflict.
        cycle(1'b0, 1'b0, 0, 0, 1'b1, 1'b0, 2, 0);
        @(negedge clk);
        apply_reset(1'b1);
        cycle(1'b1, 1'b0, 9, 0, 1'b1, 1'b0, 2, 0);
        cycle(1'b0, 1'b0, 0, 0, 1'b1, 1'b0, 2, 0);
        cycle(1'b0, 1'b0, 0, 0, 1'b0, 1'b0, 0, 0);
        end_test("reset_hold");

        random_traffic(400);
        end_test("random");

        $display("tests %0d, failed %0d, value errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, uut.u_chk.fail_count);
        if (errors == 0 && tests_failed == 0 && !timed_out && uut.u_chk.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
logic/mem_pkg.sv
logic/mem_arbiter.sv
logic/port_mux.sv
logic/shared_ram.sv
logic/read_return.sv
logic/mem_subsystem.sv
testbench/mem_subsystem_chk.sv
testbench/tb_mem_subsystem.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsystem \
    -f list.f \
    -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
else
    exit 1
fi
